//--- project.f
common/axi_perf_pkg.sv
axi_perf_monitor/axi_event_capture.sv
axi_perf_monitor/axi_latency_tracker.sv
logic/perf_stat_accum.sv
logic/perf_readout.sv
axi_perf_monitor/axi_perf_monitor_top.sv
verification/axi_perf_assertions.sv
verification/axi_perf_tb.sv

//--- verification/axi_perf_tb.sv
//////////////////////////////
// AXI performance monitor testbench
// Directed AXI handshake sequences with
// a reference model built from the
// recorded handshake cycles
//////////////////////////////

module axi_perf_tb;
  import axi_perf_pkg::*;

  localparam int unsigned ID_W        = 4;
  localparam int unsigned TRACK_DEPTH = 8;
  localparam int unsigned IDLE_CYCLES = 10;

  // Cycle budgets of reset and the six tests
  localparam int unsigned RESET_BUDGET   = 8;
  localparam int unsigned TEST_BUDGET    = 40 + 220 + 120 + 220 + 200 + 60;
  localparam int unsigned TIMEOUT_CYCLES = RESET_BUDGET + TEST_BUDGET + 200;

  logic              clk_i;
  logic              rst_n_i;
  logic              ar_valid_i;
  logic              ar_ready_i;
  logic [ID_W-1:0]   ar_id_i;
  logic              aw_valid_i;
  logic              aw_ready_i;
  logic [ID_W-1:0]   aw_id_i;
  logic              w_valid_i;
  logic              w_ready_i;
  logic              r_valid_i;
  logic              r_ready_i;
  logic [ID_W-1:0]   r_id_i;
  logic              r_last_i;
  logic              b_valid_i;
  logic              b_ready_i;
  logic [ID_W-1:0]   b_id_i;
  logic              en_i;
  logic              clear_i;
  stat_e             stat_sel_i;
  logic [STAT_W-1:0] stat_o;
  logic [STAT_W-1:0] ar_in_flight_o;
  logic [STAT_W-1:0] aw_in_flight_o;
  logic              err_o;

  int unsigned cycle_q        = 0;
  int unsigned mismatch_count = 0;
  int unsigned failure_count  = 0;
  int unsigned seed_value;

  // Reference model of the statistics
  logic [STAT_W-1:0] exp_ar;
  logic [STAT_W-1:0] exp_aw;
  logic [STAT_W-1:0] exp_r_beats;
  logic [STAT_W-1:0] exp_w_beats;
  logic [STAT_W-1:0] exp_rd_done;
  logic [STAT_W-1:0] exp_wr_done;
  logic [STAT_W-1:0] exp_rd_sum;
  logic [STAT_W-1:0] exp_wr_sum;
  logic [STAT_W-1:0] exp_rd_max;
  logic [STAT_W-1:0] exp_wr_max;
  logic [STAT_W-1:0] exp_flags;

  axi_perf_monitor_top #(
    .IdWidth    (ID_W),
    .TrackDepth (TRACK_DEPTH)
  ) dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_i     (ar_ready_i),
    .ar_id_i        (ar_id_i),
    .aw_valid_i     (aw_valid_i),
    .aw_ready_i     (aw_ready_i),
    .aw_id_i        (aw_id_i),
    .w_valid_i      (w_valid_i),
    .w_ready_i      (w_ready_i),
    .r_valid_i      (r_valid_i),
    .r_ready_i      (r_ready_i),
    .r_id_i         (r_id_i),
    .r_last_i       (r_last_i),
    .b_valid_i      (b_valid_i),
    .b_ready_i      (b_ready_i),
    .b_id_i         (b_id_i),
    .en_i           (en_i),
    .clear_i        (clear_i),
    .stat_sel_i     (stat_sel_i),
    .stat_o         (stat_o),
    .ar_in_flight_o (ar_in_flight_o),
    .aw_in_flight_o (aw_in_flight_o),
    .err_o          (err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_q <= cycle_q + 1;
    if (cycle_q >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic void clear_model();
    exp_ar      = '0;
    exp_aw      = '0;
    exp_r_beats = '0;
    exp_w_beats = '0;
    exp_rd_done = '0;
    exp_wr_done = '0;
    exp_rd_sum  = '0;
    exp_wr_sum  = '0;
    exp_rd_max  = '0;
    exp_wr_max  = '0;
    exp_flags   = '0;
  endfunction

  // Latency is the distance between the two handshake edges
  function automatic void note_read(input int unsigned req_at, input int unsigned cpl_at);
    logic [STAT_W-1:0] lat;
    lat         = STAT_W'(cpl_at - req_at);
    exp_rd_done = exp_rd_done + 1'b1;
    exp_rd_sum  = exp_rd_sum + lat;
    if (lat > exp_rd_max) begin
      exp_rd_max = lat;
    end
  endfunction

  function automatic void note_write(input int unsigned req_at, input int unsigned cpl_at);
    logic [STAT_W-1:0] lat;
    lat         = STAT_W'(cpl_at - req_at);
    exp_wr_done = exp_wr_done + 1'b1;
    exp_wr_sum  = exp_wr_sum + lat;
    if (lat > exp_wr_max) begin
      exp_wr_max = lat;
    end
  endfunction

  task automatic idle(input int unsigned n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic random_gap();
    idle(1 + ($urandom % 4));
  endtask

  // Every driver starts and returns right after a rising edge
  task automatic send_ar(input logic [ID_W-1:0] id, output int unsigned at);
    ar_valid_i <= 1'b1;
    ar_id_i    <= id;
    @(posedge clk_i);
    at = cycle_q;
    ar_valid_i <= 1'b0;
    if (en_i) begin
      exp_ar = exp_ar + 1'b1;
    end
  endtask

  task automatic send_aw(input logic [ID_W-1:0] id, output int unsigned at);
    aw_valid_i <= 1'b1;
    aw_id_i    <= id;
    @(posedge clk_i);
    at = cycle_q;
    aw_valid_i <= 1'b0;
    if (en_i) begin
      exp_aw = exp_aw + 1'b1;
    end
  endtask

  task automatic send_w(input int unsigned beats);
    w_valid_i <= 1'b1;
    repeat (beats) @(posedge clk_i);
    w_valid_i <= 1'b0;
    if (en_i) begin
      exp_w_beats = exp_w_beats + beats;
    end
  endtask

  task automatic send_r(input logic [ID_W-1:0] id, input int beats, output int unsigned first_at);
    r_valid_i <= 1'b1;
    r_id_i    <= id;
    r_last_i  <= (beats == 1);
    for (int b = 0; b < beats; b++) begin
      @(posedge clk_i);
      if (b == 0) begin
        first_at = cycle_q;
      end
      r_last_i <= (b + 2 == beats);
    end
    r_valid_i <= 1'b0;
    r_last_i  <= 1'b0;
    if (en_i) begin
      exp_r_beats = exp_r_beats + beats;
    end
  endtask

  task automatic send_b(input logic [ID_W-1:0] id, output int unsigned at);
    b_valid_i <= 1'b1;
    b_id_i    <= id;
    @(posedge clk_i);
    at = cycle_q;
    b_valid_i <= 1'b0;
  endtask

  // A count stays selected so the readout shows the zeroed counters
  task automatic pulse_clear();
    clear_i    <= 1'b1;
    stat_sel_i <= STAT_AR_COUNT;
    @(posedge clk_i);
    clear_i <= 1'b0;
    clear_model();
  endtask

  // Select, let the readout register load, then sample
  task automatic check_stat(input stat_e sel, input logic [STAT_W-1:0] exp);
    stat_sel_i <= sel;
    @(posedge clk_i);
    @(posedge clk_i);
    if (stat_o !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, sel.name(), exp, stat_o);
    end
  endtask

  task automatic check_count(input string what, input logic [STAT_W-1:0] got,
                             input logic [STAT_W-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_all();
    check_stat(STAT_AR_COUNT, exp_ar);
    check_stat(STAT_AW_COUNT, exp_aw);
    check_stat(STAT_R_BEATS, exp_r_beats);
    check_stat(STAT_W_BEATS, exp_w_beats);
    check_stat(STAT_RD_DONE, exp_rd_done);
    check_stat(STAT_WR_DONE, exp_wr_done);
    check_stat(STAT_RD_LAT_SUM, exp_rd_sum);
    check_stat(STAT_WR_LAT_SUM, exp_wr_sum);
    check_stat(STAT_RD_LAT_MAX, exp_rd_max);
    check_stat(STAT_WR_LAT_MAX, exp_wr_max);
    check_stat(STAT_FLAGS, exp_flags);
  endtask

  task automatic wait_in_flight_drained(input int unsigned limit);
    int unsigned n;
    n = 0;
    while ((ar_in_flight_o != '0 || aw_in_flight_o != '0) && n < limit) begin
      @(posedge clk_i);
      n++;
    end
    if (ar_in_flight_o != '0 || aw_in_flight_o != '0) begin
      failure_count++;
      $display("failure at %0t: in-flight counts did not drain within %0d cycles", $time, limit);
    end
  endtask

  task automatic test_reset_state();
    check_count("ar_in_flight_o", ar_in_flight_o, '0);
    check_count("aw_in_flight_o", aw_in_flight_o, '0);
    check_flag("err_o", err_o, 1'b0);
    check_all();
    check_stat(STAT_CYCLES, '0);
  endtask

  task automatic test_single_transfers();
    int unsigned ar_at;
    int unsigned aw_at;
    int unsigned r_at;
    int unsigned b_at;
    en_i <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      send_ar(ID_W'(i), ar_at);
      random_gap();
      send_aw(ID_W'(i + 8), aw_at);
      random_gap();
      send_w(1);
      random_gap();
      send_r(ID_W'(i), 1, r_at);
      random_gap();
      send_b(ID_W'(i + 8), b_at);
      note_read(ar_at, r_at);
      note_write(aw_at, b_at);
      random_gap();
    end
    idle(IDLE_CYCLES);
    check_all();
  endtask

  task automatic test_burst_reads();
    int unsigned ar_at;
    int unsigned r_at;
    for (int i = 0; i < 3; i++) begin
      send_ar(ID_W'(3), ar_at);
      random_gap();
      send_r(ID_W'(3), 2 + i, r_at);
      note_read(ar_at, r_at);
      random_gap();
    end
    idle(IDLE_CYCLES);
    check_all();
    check_count("ar_in_flight_o", ar_in_flight_o, '0);
  endtask

  task automatic test_outstanding();
    int unsigned req_at [3];
    int unsigned cpl_at [3];
    for (int i = 0; i < 3; i++) begin
      send_ar(ID_W'(2), req_at[i]);
      random_gap();
    end
    idle(3);
    check_count("ar_in_flight_o", ar_in_flight_o, STAT_W'(3));
    // Completions pair with the oldest request of the ID
    for (int i = 0; i < 3; i++) begin
      send_r(ID_W'(2), 2, cpl_at[i]);
      note_read(req_at[i], cpl_at[i]);
      random_gap();
    end
    for (int i = 0; i < 3; i++) begin
      send_aw(ID_W'(5), req_at[i]);
      send_w(2);
      random_gap();
    end
    idle(3);
    check_count("aw_in_flight_o", aw_in_flight_o, STAT_W'(3));
    for (int i = 0; i < 3; i++) begin
      send_b(ID_W'(5), cpl_at[i]);
      note_write(req_at[i], cpl_at[i]);
      random_gap();
    end
    wait_in_flight_drained(20);
    idle(IDLE_CYCLES);
    check_all();
  endtask

  task automatic test_window_and_clear();
    int unsigned at;
    int unsigned ar_at;
    int unsigned on_cycles;
    en_i <= 1'b0;
    pulse_clear();
    // Full transactions outside the window leave no trace
    send_ar(ID_W'(1), at);
    send_aw(ID_W'(9), at);
    send_w(2);
    send_r(ID_W'(1), 3, at);
    send_b(ID_W'(9), at);
    idle(IDLE_CYCLES);
    on_cycles = 5 + ($urandom % 8);
    en_i <= 1'b1;
    idle(on_cycles);
    en_i <= 1'b0;
    check_all();
    check_stat(STAT_CYCLES, STAT_W'(on_cycles));
    en_i <= 1'b1;
    send_ar(ID_W'(1), ar_at);
    send_r(ID_W'(1), 1, at);
    note_read(ar_at, at);
    send_aw(ID_W'(9), ar_at);
    send_w(1);
    send_b(ID_W'(9), at);
    note_write(ar_at, at);
    idle(IDLE_CYCLES);
    check_all();
    en_i <= 1'b0;
    pulse_clear();
    check_all();
    check_stat(STAT_CYCLES, '0);
    en_i <= 1'b1;
  endtask

  task automatic test_orphan_response();
    int unsigned at;
    send_b(ID_W'(7), at);
    // No AW was ever sent on this ID
    exp_flags = STAT_W'(1);
    idle(IDLE_CYCLES);
    check_flag("err_o", err_o, 1'b1);
    check_stat(STAT_FLAGS, exp_flags);
    pulse_clear();
    idle(2);
    check_flag("err_o", err_o, 1'b0);
    check_stat(STAT_FLAGS, exp_flags);
  endtask

  initial begin
    seed_value = $urandom(376);
    clear_model();
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_ready_i = 1'b1;
    ar_id_i    = '0;
    aw_valid_i = 1'b0;
    aw_ready_i = 1'b1;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_ready_i  = 1'b1;
    r_valid_i  = 1'b0;
    r_ready_i  = 1'b1;
    r_id_i     = '0;
    r_last_i   = 1'b0;
    b_valid_i  = 1'b0;
    b_ready_i  = 1'b1;
    b_id_i     = '0;
    en_i       = 1'b0;
    clear_i    = 1'b0;
    stat_sel_i = STAT_AR_COUNT;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    test_reset_state();
    test_single_transfers();
    test_burst_reads();
    test_outstanding();
    test_window_and_clear();
    test_orphan_response();
    $display("errors: %0d value mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verification/axi_perf_assertions.sv
//////////////////////////////
// AXI performance monitor checks
// Concurrent properties on the
// monitor top level
//////////////////////////////

module axi_perf_assertions
  import axi_perf_pkg::*;
#(
  parameter int unsigned IdWidth    = 4,
  parameter int unsigned TrackDepth = 8
) (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              clear_i,
  input stat_e             stat_sel_i,
  input logic [STAT_W-1:0] stat_i,
  input logic [STAT_W-1:0] ar_in_flight_i,
  input logic [STAT_W-1:0] aw_in_flight_i,
  input logic              r_valid_i,
  input logic              r_ready_i,
  input logic              r_last_i,
  input rd_burst_e         rd_state_i
);

  localparam int unsigned MaxInFlight = (2 ** IdWidth) * TrackDepth;

  logic sel_is_count;

  assign sel_is_count = stat_sel_i inside {STAT_AR_COUNT, STAT_AW_COUNT, STAT_R_BEATS,
                                           STAT_W_BEATS, STAT_RD_DONE, STAT_WR_DONE};

  // Every tracked request sits in one per-ID queue
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_in_flight_i <= STAT_W'(MaxInFlight))
    else $error("read in-flight count exceeds the queue capacity");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_in_flight_i <= STAT_W'(MaxInFlight))
    else $error("write in-flight count exceeds the queue capacity");

  // Readout register picks up the zeroed counters one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clear_i ##1 sel_is_count |=> (stat_i == '0))
    else $error("count readout not zero after a clear");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_i && r_ready_i && r_last_i) |=> (rd_state_i == RD_IDLE))
    else $error("read-burst state not idle after a last beat");

endmodule

bind axi_perf_monitor_top axi_perf_assertions #(
  .IdWidth    (IdWidth),
  .TrackDepth (TrackDepth)
) u_assertions (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .clear_i        (clear_i),
  .stat_sel_i     (stat_sel_i),
  .stat_i         (stat_o),
  .ar_in_flight_i (ar_in_flight_o),
  .aw_in_flight_i (aw_in_flight_o),
  .r_valid_i      (r_valid_i),
  .r_ready_i      (r_ready_i),
  .r_last_i       (r_last_i),
  .rd_state_i     (u_capture.rd_state_q)
);

//--- axi_perf_monitor/axi_perf_monitor_top.sv
//////////////////////////////
// AXI4 performance monitor
// Passive observer of one AXI4 link with
// per-ID latency tracking and a selectable
// statistics readout
//////////////////////////////

module axi_perf_monitor_top
  import axi_perf_pkg::*;
#(
  parameter int unsigned IdWidth    = 4,
  parameter int unsigned TrackDepth = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ar_valid_i,
  input  logic               ar_ready_i,
  input  logic [IdWidth-1:0] ar_id_i,
  input  logic               aw_valid_i,
  input  logic               aw_ready_i,
  input  logic [IdWidth-1:0] aw_id_i,
  input  logic               w_valid_i,
  input  logic               w_ready_i,
  input  logic               r_valid_i,
  input  logic               r_ready_i,
  input  logic [IdWidth-1:0] r_id_i,
  input  logic               r_last_i,
  input  logic               b_valid_i,
  input  logic               b_ready_i,
  input  logic [IdWidth-1:0] b_id_i,
  input  logic               en_i,
  input  logic               clear_i,
  input  stat_e              stat_sel_i,
  output logic [STAT_W-1:0]  stat_o,
  output logic [STAT_W-1:0]  ar_in_flight_o,
  output logic [STAT_W-1:0]  aw_in_flight_o,
  output logic               err_o
);

  logic               ar_evt;
  logic [IdWidth-1:0] ar_id;
  logic               aw_evt;
  logic [IdWidth-1:0] aw_id;
  logic               w_beat;
  logic               r_beat;
  logic               r_first;
  logic [IdWidth-1:0] r_id;
  logic               b_evt;
  logic [IdWidth-1:0] b_id;

  logic               rd_done;
  logic [STAT_W-1:0]  rd_lat;
  logic               wr_done;
  logic [STAT_W-1:0]  wr_lat;
  logic               trk_err;

  logic [STAT_W-1:0]  ar_count;
  logic [STAT_W-1:0]  aw_count;
  logic [STAT_W-1:0]  r_beats;
  logic [STAT_W-1:0]  w_beats;
  logic [STAT_W-1:0]  rd_done_cnt;
  logic [STAT_W-1:0]  wr_done_cnt;
  logic [STAT_W-1:0]  rd_lat_sum;
  logic [STAT_W-1:0]  wr_lat_sum;
  logic [STAT_W-1:0]  rd_lat_max;
  logic [STAT_W-1:0]  wr_lat_max;
  logic [STAT_W-1:0]  cycles;

  axi_event_capture #(
    .IdWidth (IdWidth)
  ) u_capture (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_i (ar_ready_i),
    .ar_id_i    (ar_id_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_i (aw_ready_i),
    .aw_id_i    (aw_id_i),
    .w_valid_i  (w_valid_i),
    .w_ready_i  (w_ready_i),
    .r_valid_i  (r_valid_i),
    .r_ready_i  (r_ready_i),
    .r_id_i     (r_id_i),
    .r_last_i   (r_last_i),
    .b_valid_i  (b_valid_i),
    .b_ready_i  (b_ready_i),
    .b_id_i     (b_id_i),
    .en_i       (en_i),
    .ar_evt_o   (ar_evt),
    .ar_id_o    (ar_id),
    .aw_evt_o   (aw_evt),
    .aw_id_o    (aw_id),
    .w_beat_o   (w_beat),
    .r_beat_o   (r_beat),
    .r_first_o  (r_first),
    .r_id_o     (r_id),
    .b_evt_o    (b_evt),
    .b_id_o     (b_id)
  );

  axi_latency_tracker #(
    .IdWidth    (IdWidth),
    .TrackDepth (TrackDepth)
  ) u_tracker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .clear_i        (clear_i),
    .ar_evt_i       (ar_evt),
    .ar_id_i        (ar_id),
    .aw_evt_i       (aw_evt),
    .aw_id_i        (aw_id),
    .r_first_i      (r_first),
    .r_id_i         (r_id),
    .b_evt_i        (b_evt),
    .b_id_i         (b_id),
    .rd_done_o      (rd_done),
    .rd_lat_o       (rd_lat),
    .wr_done_o      (wr_done),
    .wr_lat_o       (wr_lat),
    .ar_in_flight_o (ar_in_flight_o),
    .aw_in_flight_o (aw_in_flight_o),
    .err_o          (trk_err)
  );

  perf_stat_accum u_accum (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .en_i         (en_i),
    .clear_i      (clear_i),
    .ar_evt_i     (ar_evt),
    .aw_evt_i     (aw_evt),
    .w_beat_i     (w_beat),
    .r_beat_i     (r_beat),
    .rd_done_i    (rd_done),
    .rd_lat_i     (rd_lat),
    .wr_done_i    (wr_done),
    .wr_lat_i     (wr_lat),
    .err_i        (trk_err),
    .ar_count_o   (ar_count),
    .aw_count_o   (aw_count),
    .r_beats_o    (r_beats),
    .w_beats_o    (w_beats),
    .rd_done_o    (rd_done_cnt),
    .wr_done_o    (wr_done_cnt),
    .rd_lat_sum_o (rd_lat_sum),
    .wr_lat_sum_o (wr_lat_sum),
    .rd_lat_max_o (rd_lat_max),
    .wr_lat_max_o (wr_lat_max),
    .cycles_o     (cycles),
    .err_flag_o   (err_o)
  );

  perf_readout u_readout (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stat_sel_i   (stat_sel_i),
    .ar_count_i   (ar_count),
    .aw_count_i   (aw_count),
    .r_beats_i    (r_beats),
    .w_beats_i    (w_beats),
    .rd_done_i    (rd_done_cnt),
    .wr_done_i    (wr_done_cnt),
    .rd_lat_sum_i (rd_lat_sum),
    .wr_lat_sum_i (wr_lat_sum),
    .rd_lat_max_i (rd_lat_max),
    .wr_lat_max_i (wr_lat_max),
    .cycles_i     (cycles),
    .err_flag_i   (err_o),
    .stat_o       (stat_o)
  );

endmodule

//--- logic/perf_readout.sv
//////////////////////////////
// Statistic readout
// Registers the statistic picked by
// the select level
//////////////////////////////

module perf_readout
  import axi_perf_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  stat_e             stat_sel_i,
  input  logic [STAT_W-1:0] ar_count_i,
  input  logic [STAT_W-1:0] aw_count_i,
  input  logic [STAT_W-1:0] r_beats_i,
  input  logic [STAT_W-1:0] w_beats_i,
  input  logic [STAT_W-1:0] rd_done_i,
  input  logic [STAT_W-1:0] wr_done_i,
  input  logic [STAT_W-1:0] rd_lat_sum_i,
  input  logic [STAT_W-1:0] wr_lat_sum_i,
  input  logic [STAT_W-1:0] rd_lat_max_i,
  input  logic [STAT_W-1:0] wr_lat_max_i,
  input  logic [STAT_W-1:0] cycles_i,
  input  logic              err_flag_i,
  output logic [STAT_W-1:0] stat_o
);

  logic [STAT_W-1:0] stat_mux;

  always_comb begin
    case (stat_sel_i)
      STAT_AR_COUNT:   stat_mux = ar_count_i;
      STAT_AW_COUNT:   stat_mux = aw_count_i;
      STAT_R_BEATS:    stat_mux = r_beats_i;
      STAT_W_BEATS:    stat_mux = w_beats_i;
      STAT_RD_DONE:    stat_mux = rd_done_i;
      STAT_WR_DONE:    stat_mux = wr_done_i;
      STAT_RD_LAT_SUM: stat_mux = rd_lat_sum_i;
      STAT_WR_LAT_SUM: stat_mux = wr_lat_sum_i;
      STAT_RD_LAT_MAX: stat_mux = rd_lat_max_i;
      STAT_WR_LAT_MAX: stat_mux = wr_lat_max_i;
      STAT_CYCLES:     stat_mux = cycles_i;
      STAT_FLAGS:      stat_mux = {{(STAT_W - 1){1'b0}}, err_flag_i};
      default:         stat_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stat_o <= '0;
    end else begin
      stat_o <= stat_mux;
    end
  end

endmodule

//--- logic/perf_stat_accum.sv
//////////////////////////////
// Statistics accumulator
// Saturating event counts, latency sums
// and maxima, window cycles and a sticky
// error flag
//////////////////////////////

module perf_stat_accum
  import axi_perf_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              en_i,
  input  logic              clear_i,
  input  logic              ar_evt_i,
  input  logic              aw_evt_i,
  input  logic              w_beat_i,
  input  logic              r_beat_i,
  input  logic              rd_done_i,
  input  logic [STAT_W-1:0] rd_lat_i,
  input  logic              wr_done_i,
  input  logic [STAT_W-1:0] wr_lat_i,
  input  logic              err_i,
  output logic [STAT_W-1:0] ar_count_o,
  output logic [STAT_W-1:0] aw_count_o,
  output logic [STAT_W-1:0] r_beats_o,
  output logic [STAT_W-1:0] w_beats_o,
  output logic [STAT_W-1:0] rd_done_o,
  output logic [STAT_W-1:0] wr_done_o,
  output logic [STAT_W-1:0] rd_lat_sum_o,
  output logic [STAT_W-1:0] wr_lat_sum_o,
  output logic [STAT_W-1:0] rd_lat_max_o,
  output logic [STAT_W-1:0] wr_lat_max_o,
  output logic [STAT_W-1:0] cycles_o,
  output logic              err_flag_o
);

  // Sticks at all ones instead of wrapping
  function automatic logic [STAT_W-1:0] sat_add(logic [STAT_W-1:0] a, logic [STAT_W-1:0] b);
    logic [STAT_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[STAT_W] ? '1 : sum[STAT_W-1:0];
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      ar_count_o   <= '0;
      aw_count_o   <= '0;
      r_beats_o    <= '0;
      w_beats_o    <= '0;
      rd_done_o    <= '0;
      wr_done_o    <= '0;
      rd_lat_sum_o <= '0;
      wr_lat_sum_o <= '0;
      rd_lat_max_o <= '0;
      wr_lat_max_o <= '0;
      cycles_o     <= '0;
      err_flag_o   <= 1'b0;
    end else begin
      if (ar_evt_i) ar_count_o <= sat_add(ar_count_o, STAT_W'(1));
      if (aw_evt_i) aw_count_o <= sat_add(aw_count_o, STAT_W'(1));
      if (r_beat_i) r_beats_o <= sat_add(r_beats_o, STAT_W'(1));
      if (w_beat_i) w_beats_o <= sat_add(w_beats_o, STAT_W'(1));
      if (en_i) cycles_o <= sat_add(cycles_o, STAT_W'(1));
      if (rd_done_i) begin
        rd_done_o    <= sat_add(rd_done_o, STAT_W'(1));
        rd_lat_sum_o <= sat_add(rd_lat_sum_o, rd_lat_i);
        if (rd_lat_i > rd_lat_max_o) begin
          rd_lat_max_o <= rd_lat_i;
        end
      end
      if (wr_done_i) begin
        wr_done_o    <= sat_add(wr_done_o, STAT_W'(1));
        wr_lat_sum_o <= sat_add(wr_lat_sum_o, wr_lat_i);
        if (wr_lat_i > wr_lat_max_o) begin
          wr_lat_max_o <= wr_lat_i;
        end
      end
      if (err_i) begin
        err_flag_o <= 1'b1;
      end
    end
  end

endmodule

//--- axi_perf_monitor/axi_latency_tracker.sv
//////////////////////////////
// AXI latency tracker
// Keeps a timestamp queue per ID for reads
// and writes, pairs completions with the
// oldest request of their ID and emits
// latency samples and in-flight counts
//////////////////////////////

module axi_latency_tracker
  import axi_perf_pkg::*;
#(
  parameter int unsigned IdWidth    = 4,
  parameter int unsigned TrackDepth = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               clear_i,
  input  logic               ar_evt_i,
  input  logic [IdWidth-1:0] ar_id_i,
  input  logic               aw_evt_i,
  input  logic [IdWidth-1:0] aw_id_i,
  input  logic               r_first_i,
  input  logic [IdWidth-1:0] r_id_i,
  input  logic               b_evt_i,
  input  logic [IdWidth-1:0] b_id_i,
  output logic               rd_done_o,
  output logic [STAT_W-1:0]  rd_lat_o,
  output logic               wr_done_o,
  output logic [STAT_W-1:0]  wr_lat_o,
  output logic [STAT_W-1:0]  ar_in_flight_o,
  output logic [STAT_W-1:0]  aw_in_flight_o,
  output logic               err_o
);

  localparam int unsigned NumIds = 2 ** IdWidth;
  localparam int unsigned PtrW   = (TrackDepth > 1) ? $clog2(TrackDepth) : 1;
  localparam int unsigned CntW   = $clog2(TrackDepth + 1);

  // Index 0 is the read direction, index 1 the write direction
  logic [1:0]              req_evt;
  logic [1:0][IdWidth-1:0] req_id;
  logic [1:0]              cpl_evt;
  logic [1:0][IdWidth-1:0] cpl_id;

  logic [TS_W-1:0] ts_q;

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(TrackDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign req_evt = {aw_evt_i, ar_evt_i};
  assign req_id  = {aw_id_i, ar_id_i};
  assign cpl_evt = {b_evt_i, r_first_i};
  assign cpl_id  = {b_id_i, r_id_i};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ts_q <= '0;
    end else begin
      ts_q <= ts_q + 1'b1;
    end
  end

  for (genvar d = 0; d < 2; d++) begin : g_dir
    logic [TS_W-1:0]   ts_mem [NumIds][TrackDepth];
    logic [PtrW-1:0]   head_q [NumIds];
    logic [PtrW-1:0]   tail_q [NumIds];
    logic [CntW-1:0]   cnt_q  [NumIds];
    logic [NumIds-1:0] id_push;
    logic [NumIds-1:0] id_pop;
    logic              pop_ok;
    logic              push_ok;
    logic              done_q;
    logic [STAT_W-1:0] lat_q;
    logic [STAT_W-1:0] in_flight_q;
    logic              err_q;

    assign pop_ok = cpl_evt[d] && (cnt_q[cpl_id[d]] != '0);

    // A full queue still accepts a push when the same ID pops in this cycle
    assign push_ok = req_evt[d] &&
                     ((cnt_q[req_id[d]] != CntW'(TrackDepth)) ||
                      (pop_ok && (cpl_id[d] == req_id[d])));

    always_comb begin
      id_push = '0;
      id_pop  = '0;
      if (push_ok) begin
        id_push[req_id[d]] = 1'b1;
      end
      if (pop_ok) begin
        id_pop[cpl_id[d]] = 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || clear_i) begin
        for (int i = 0; i < NumIds; i++) begin
          head_q[i] <= '0;
          tail_q[i] <= '0;
          cnt_q[i]  <= '0;
        end
        in_flight_q <= '0;
        done_q      <= 1'b0;
        err_q       <= 1'b0;
      end else begin
        for (int i = 0; i < NumIds; i++) begin
          if (id_push[i]) begin
            tail_q[i] <= next_ptr(tail_q[i]);
          end
          if (id_pop[i]) begin
            head_q[i] <= next_ptr(head_q[i]);
          end
          if (id_push[i] && !id_pop[i]) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
          end else if (id_pop[i] && !id_push[i]) begin
            cnt_q[i] <= cnt_q[i] - 1'b1;
          end
        end
        if (push_ok && !pop_ok) begin
          in_flight_q <= in_flight_q + 1'b1;
        end else if (pop_ok && !push_ok) begin
          in_flight_q <= in_flight_q - 1'b1;
        end
        done_q <= pop_ok;
        err_q  <= (cpl_evt[d] && !pop_ok) || (req_evt[d] && !push_ok);
      end
    end

    // Old entry is read before the write lands, so a full-queue swap is safe
    always_ff @(posedge clk_i) begin
      if (push_ok) begin
        ts_mem[req_id[d]][tail_q[req_id[d]]] <= ts_q;
      end
      if (pop_ok) begin
        lat_q <= STAT_W'(ts_q - ts_mem[cpl_id[d]][head_q[cpl_id[d]]]);
      end
    end
  end

  assign rd_done_o      = g_dir[0].done_q;
  assign rd_lat_o       = g_dir[0].lat_q;
  assign ar_in_flight_o = g_dir[0].in_flight_q;
  assign wr_done_o      = g_dir[1].done_q;
  assign wr_lat_o       = g_dir[1].lat_q;
  assign aw_in_flight_o = g_dir[1].in_flight_q;
  assign err_o          = g_dir[0].err_q || g_dir[1].err_q;

endmodule

//--- axi_perf_monitor/axi_event_capture.sv
//////////////////////////////
// AXI event capture
// Detects the five AXI handshakes inside
// the enabled window and registers them
// as one-cycle strobes with their IDs.
// Also marks the first beat of each R burst.
//////////////////////////////

module axi_event_capture
  import axi_perf_pkg::*;
#(
  parameter int unsigned IdWidth = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ar_valid_i,
  input  logic               ar_ready_i,
  input  logic [IdWidth-1:0] ar_id_i,
  input  logic               aw_valid_i,
  input  logic               aw_ready_i,
  input  logic [IdWidth-1:0] aw_id_i,
  input  logic               w_valid_i,
  input  logic               w_ready_i,
  input  logic               r_valid_i,
  input  logic               r_ready_i,
  input  logic [IdWidth-1:0] r_id_i,
  input  logic               r_last_i,
  input  logic               b_valid_i,
  input  logic               b_ready_i,
  input  logic [IdWidth-1:0] b_id_i,
  input  logic               en_i,
  output logic               ar_evt_o,
  output logic [IdWidth-1:0] ar_id_o,
  output logic               aw_evt_o,
  output logic [IdWidth-1:0] aw_id_o,
  output logic               w_beat_o,
  output logic               r_beat_o,
  output logic               r_first_o,
  output logic [IdWidth-1:0] r_id_o,
  output logic               b_evt_o,
  output logic [IdWidth-1:0] b_id_o
);

  logic ar_hs;
  logic aw_hs;
  logic w_hs;
  logic r_hs;
  logic b_hs;

  rd_burst_e rd_state_q;

  assign ar_hs = ar_valid_i && ar_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_i;
  assign w_hs  = w_valid_i && w_ready_i;
  assign r_hs  = r_valid_i && r_ready_i;
  assign b_hs  = b_valid_i && b_ready_i;

  // Burst position follows the link even outside the window
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_state_q <= RD_IDLE;
    end else if (r_hs) begin
      rd_state_q <= r_last_i ? RD_IDLE : RD_IN_BURST;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ar_evt_o  <= 1'b0;
      aw_evt_o  <= 1'b0;
      w_beat_o  <= 1'b0;
      r_beat_o  <= 1'b0;
      r_first_o <= 1'b0;
      b_evt_o   <= 1'b0;
    end else begin
      ar_evt_o  <= en_i && ar_hs;
      aw_evt_o  <= en_i && aw_hs;
      w_beat_o  <= en_i && w_hs;
      r_beat_o  <= en_i && r_hs;
      r_first_o <= en_i && r_hs && (rd_state_q == RD_IDLE);
      b_evt_o   <= en_i && b_hs;
    end
  end

  // IDs only matter alongside their strobe
  always_ff @(posedge clk_i) begin
    ar_id_o <= ar_id_i;
    aw_id_o <= aw_id_i;
    r_id_o  <= r_id_i;
    b_id_o  <= b_id_i;
  end

endmodule

//--- common/axi_perf_pkg.sv
//////////////////////////////
// AXI performance monitor package
// Statistic select codes, read-burst
// state and shared widths
//////////////////////////////

package axi_perf_pkg;

  // Width of every statistic, counter and readout
  localparam int unsigned STAT_W = 32;

  // Width of the free-running timestamp
  localparam int unsigned TS_W = 32;

  // Statistic select codes for the readout port
  typedef enum logic [3:0] {
    STAT_AR_COUNT   = 4'd0,
    STAT_AW_COUNT   = 4'd1,
    STAT_R_BEATS    = 4'd2,
    STAT_W_BEATS    = 4'd3,
    STAT_RD_DONE    = 4'd4,
    STAT_WR_DONE    = 4'd5,
    STAT_RD_LAT_SUM = 4'd6,
    STAT_WR_LAT_SUM = 4'd7,
    STAT_RD_LAT_MAX = 4'd8,
    STAT_WR_LAT_MAX = 4'd9,
    STAT_CYCLES     = 4'd10,
    STAT_FLAGS      = 4'd11
  } stat_e;

  // Position of the capture inside an R burst
  typedef enum logic {
    RD_IDLE     = 1'b0,
    RD_IN_BURST = 1'b1
  } rd_burst_e;

endpackage
